// File: run_sim.sh
#!/usr/bin/env bash
# build and run clock_tb with Verilator, result taken from the log
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module clock_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vclock_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi

if ! grep -q "Simulation passed" "$log"; then
    echo "no result found in $log"
    exit 1
fi

exit 0

// File: source/clock.sv
module clock #(
    parameter int unsigned TICK_DIV   = 100_000_000,
    parameter int unsigned EDIT_DIV   = 25_000_000,
    parameter int unsigned SCAN_DIV   = 50_000,
    parameter int unsigned SEC_RANGE  = 60,
    parameter int unsigned MIN_RANGE  = 60,
    parameter int unsigned HOUR_RANGE = 24,
    parameter int unsigned LEN        = 30,
    parameter int unsigned NUM        = 5
) (
    input  logic                 clk_src,
    input  logic                 rst_n,
    input  logic                 power,
    input  logic                 enable,
    input  logic                 reset,
    input  clock_pkg::unit_sel_t add_time,
    input  clock_pkg::unit_sel_t sub_time,
    input  logic                 timing_clock_switch,
    input  logic                 timing_clock_disable,
    output logic                 alarm,
    output logic [NUM-1:0]       timing_clock_alarm,
    output logic [7:0]           anodes,
    output logic [7:0]           cnodes
);

    logic                         sec_tick;
    logic                         edit_tick;
    logic                         scan_tick;
    logic                         sec_carry;
    logic                         min_carry;
    logic                         clear;
    logic                         edit_lock;
    logic [clock_pkg::unit_w-1:0] sec_count;
    logic [clock_pkg::unit_w-1:0] min_count;
    logic [clock_pkg::unit_w-1:0] hour_count;
    clock_pkg::clock_time_t       now;
    clock_pkg::clock_time_t       show_time;
    clock_pkg::clock_time_t       shown;

    // counters hold while powered off
    assign clear = reset & power;

    // manual clock edits locked while an alarm slot is edited
    assign edit_lock = timing_clock_switch | ~power;

    tick_divider #(
        .TICK_DIV(TICK_DIV),
        .EDIT_DIV(EDIT_DIV),
        .SCAN_DIV(SCAN_DIV)
    ) tick_div (
        .clk_src(clk_src), .rst_n(rst_n), .power(power), .enable(enable),
        .sec_tick(sec_tick), .edit_tick(edit_tick), .scan_tick(scan_tick)
    );

    timer #(.RANGE(SEC_RANGE)) sec_timer (
        .clk_src(clk_src), .rst_n(rst_n), .reset(clear), .step(sec_tick),
        .edit_tick(edit_tick), .edit_lock(edit_lock),
        .add(add_time.sec), .sub(sub_time.sec),
        .count(sec_count), .carry_out(sec_carry)
    );

    timer #(.RANGE(MIN_RANGE)) min_timer (
        .clk_src(clk_src), .rst_n(rst_n), .reset(clear), .step(sec_carry),
        .edit_tick(edit_tick), .edit_lock(edit_lock),
        .add(add_time.min), .sub(sub_time.min),
        .count(min_count), .carry_out(min_carry)
    );

    // day wrap goes nowhere
    timer #(.RANGE(HOUR_RANGE)) hour_timer (
        .clk_src(clk_src), .rst_n(rst_n), .reset(clear), .step(min_carry),
        .edit_tick(edit_tick), .edit_lock(edit_lock),
        .add(add_time.hour), .sub(sub_time.hour),
        .count(hour_count), .carry_out()
    );

    assign now = '{hour: hour_count, min: min_count, sec: sec_count};

    timing_clock #(
        .NUM(NUM),
        .MIN_RANGE(MIN_RANGE),
        .HOUR_RANGE(HOUR_RANGE)
    ) slots (
        .clk_src(clk_src), .rst_n(rst_n), .reset(clear), .power(power),
        .timing_clock_switch(timing_clock_switch),
        .timing_clock_disable(timing_clock_disable),
        .edit_tick(edit_tick), .add_time(add_time), .sub_time(sub_time),
        .now(now), .show_time(show_time), .timing_clock_alarm(timing_clock_alarm)
    );

    ring #(
        .LEN(LEN),
        .SEC_RANGE(SEC_RANGE),
        .MIN_RANGE(MIN_RANGE)
    ) chime (
        .clk_src(clk_src), .rst_n(rst_n), .power(power), .enable(enable),
        .sec_tick(sec_tick), .now(now), .alarm(alarm)
    );

    // the slot under edit replaces the running time on the display
    assign shown = timing_clock_switch ? show_time : now;

    time_displayer display (
        .clk_src(clk_src), .rst_n(rst_n), .power(power), .scan_tick(scan_tick),
        .shown(shown), .anodes(anodes), .cnodes(cnodes)
    );

endmodule

// File: source/clock_pkg.sv
package clock_pkg;

    // width of one time unit counter
    localparam int unsigned unit_w = 6;

    // running time or an alarm slot
    typedef struct packed {
        logic [unit_w-1:0] hour;
        logic [unit_w-1:0] min;
        logic [unit_w-1:0] sec;
    } clock_time_t;

    // one-hot unit pick, bit 0 is sec
    typedef struct packed {
        logic hour;
        logic min;
        logic sec;
    } unit_sel_t;

    localparam clock_time_t time_zero = '{hour: '0, min: '0, sec: '0};

    // all segments and the point dark
    localparam logic [7:0] seg_blank = 8'hff;

    // active low, bit order {dp, g, f, e, d, c, b, a}
    function automatic logic [7:0] seg_code(input logic [3:0] digit);
        case (digit)
            4'd0: return 8'hc0;
            4'd1: return 8'hf9;
            4'd2: return 8'ha4;
            4'd3: return 8'hb0;
            4'd4: return 8'h99;
            4'd5: return 8'h92;
            4'd6: return 8'h82;
            4'd7: return 8'hf8;
            4'd8: return 8'h80;
            4'd9: return 8'h90;
            default: return seg_blank;
        endcase
    endfunction

    function automatic logic [3:0] digit_tens(input logic [unit_w-1:0] value);
        return 4'(value / unit_w'(10));
    endfunction

    function automatic logic [3:0] digit_ones(input logic [unit_w-1:0] value);
        return 4'(value % unit_w'(10));
    endfunction

endpackage

// File: source/ring.sv
module ring #(
    parameter int unsigned LEN       = 30,
    parameter int unsigned SEC_RANGE = 60,
    parameter int unsigned MIN_RANGE = 60
) (
    input  logic                   clk_src,
    input  logic                   rst_n,
    input  logic                   power,
    input  logic                   enable,
    input  logic                   sec_tick,
    input  clock_pkg::clock_time_t now,
    output logic                   alarm
);

    localparam int unsigned len_w = $clog2(LEN + 1);
    localparam logic [clock_pkg::unit_w-1:0] sec_top = clock_pkg::unit_w'(SEC_RANGE - 1);
    localparam logic [clock_pkg::unit_w-1:0] min_top = clock_pkg::unit_w'(MIN_RANGE - 1);

    logic             at_hour_end;
    logic             rollover;
    logic [len_w-1:0] left;

    // last cycle showed mm:ss at the top, this one shows 00:00
    assign rollover = at_hour_end & enable & (now.min == '0) & (now.sec == '0);

    always_ff @(posedge clk_src or negedge rst_n) begin
        if (!rst_n) begin
            at_hour_end <= 1'b0;
            left        <= '0;
            alarm       <= 1'b0;
        end else begin
            at_hour_end <= (now.min == min_top) && (now.sec == sec_top);
            if (!power) begin
                alarm <= 1'b0;
                left  <= '0;
            end else if (rollover) begin
                alarm <= 1'b1;
                left  <= len_w'(LEN);
            end else if (alarm && sec_tick) begin
                // drop on the LEN-th second
                left  <= left - 1'b1;
                alarm <= (left != len_w'(1));
            end
        end
    end

endmodule

// File: source/tick_divider.sv
module tick_divider #(
    parameter int unsigned TICK_DIV = 100_000_000,
    parameter int unsigned EDIT_DIV = 25_000_000,
    parameter int unsigned SCAN_DIV = 50_000
) (
    input  logic clk_src,
    input  logic rst_n,
    input  logic power,
    input  logic enable,
    output logic sec_tick,
    output logic edit_tick,
    output logic scan_tick
);

    localparam int unsigned max_div = (TICK_DIV > EDIT_DIV) ?
        ((TICK_DIV > SCAN_DIV) ? TICK_DIV : SCAN_DIV) :
        ((EDIT_DIV > SCAN_DIV) ? EDIT_DIV : SCAN_DIV);
    localparam int unsigned cnt_w = $clog2(max_div + 1);

    // index 0 sec, 1 edit repeat, 2 scan
    localparam logic [2:0][31:0] div_list = {32'(SCAN_DIV), 32'(EDIT_DIV), 32'(TICK_DIV)};

    logic [2:0] run;
    logic [2:0] strobe;

    // only the second counter stops, a pause keeps the partial second
    assign run = {2'b11, power & enable};

    for (genvar i = 0; i < 3; i++) begin : g_div
        logic [cnt_w-1:0] cnt;
        logic             tick_q;

        always_ff @(posedge clk_src or negedge rst_n) begin
            if (!rst_n) begin
                cnt    <= '0;
                tick_q <= 1'b0;
            end else begin
                tick_q <= 1'b0;
                if (run[i]) begin
                    if (cnt == cnt_w'(div_list[i] - 1)) begin
                        cnt    <= '0;
                        tick_q <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            end
        end

        assign strobe[i] = tick_q;
    end

    assign sec_tick  = strobe[0];
    assign edit_tick = strobe[1];
    assign scan_tick = strobe[2];

    // the carry chain relies on single-cycle second strobes
    sec_tick_single: assert property (
        @(posedge clk_src) disable iff (!rst_n) sec_tick |=> !sec_tick
    );

endmodule

// File: source/time_displayer.sv
module time_displayer (
    input  logic                   clk_src,
    input  logic                   rst_n,
    input  logic                   power,
    input  logic                   scan_tick,
    input  clock_pkg::clock_time_t shown,
    output logic [7:0]             anodes,
    output logic [7:0]             cnodes
);

    logic [2:0] digit_sel;
    logic [3:0] hour_tens;
    logic [3:0] hour_ones;
    logic [3:0] min_tens;
    logic [3:0] min_ones;
    logic [3:0] sec_tens;
    logic [3:0] sec_ones;
    logic [7:0] digit_code;

    // decimal split of each unit
    assign hour_tens = clock_pkg::digit_tens(shown.hour);
    assign hour_ones = clock_pkg::digit_ones(shown.hour);
    assign min_tens  = clock_pkg::digit_tens(shown.min);
    assign min_ones  = clock_pkg::digit_ones(shown.min);
    assign sec_tens  = clock_pkg::digit_tens(shown.sec);
    assign sec_ones  = clock_pkg::digit_ones(shown.sec);

    // digit 7 is the leftmost one
    always_comb begin
        case (digit_sel)
            3'd7: digit_code = clock_pkg::seg_code(hour_tens);
            3'd6: digit_code = clock_pkg::seg_code(hour_ones);
            3'd4: digit_code = clock_pkg::seg_code(min_tens);
            3'd3: digit_code = clock_pkg::seg_code(min_ones);
            3'd1: digit_code = clock_pkg::seg_code(sec_tens);
            3'd0: digit_code = clock_pkg::seg_code(sec_ones);
            // separators
            default: digit_code = clock_pkg::seg_blank;
        endcase
    end

    always_ff @(posedge clk_src or negedge rst_n) begin
        if (!rst_n) begin
            digit_sel <= '0;
            anodes    <= '1;
            cnodes    <= '1;
        end else if (!power) begin
            // whole display dark
            anodes <= '1;
            cnodes <= '1;
        end else if (scan_tick) begin
            anodes    <= ~(8'd1 << digit_sel);
            cnodes    <= digit_code;
            digit_sel <= digit_sel + 1'b1;
        end
    end

endmodule

// File: source/timer.sv
module timer #(
    parameter int unsigned RANGE = 60
) (
    input  logic                         clk_src,
    input  logic                         rst_n,
    input  logic                         reset,
    input  logic                         step,
    input  logic                         edit_tick,
    input  logic                         edit_lock,
    input  logic                         add,
    input  logic                         sub,
    output logic [clock_pkg::unit_w-1:0] count,
    output logic                         carry_out
);

    localparam logic [clock_pkg::unit_w-1:0] top_value = clock_pkg::unit_w'(RANGE - 1);

    logic                         at_top;
    logic                         at_zero;
    logic [clock_pkg::unit_w-1:0] count_up;
    logic [clock_pkg::unit_w-1:0] count_down;

    assign at_top  = (count == top_value);
    assign at_zero = (count == '0);

    // wrapping neighbours of the current value
    assign count_up   = at_top ? '0 : count + 1'b1;
    assign count_down = at_zero ? top_value : count - 1'b1;

    // combinational so a full wrap ripples through all units in one cycle
    assign carry_out = step & at_top & ~reset;

    always_ff @(posedge clk_src or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (reset) begin
            count <= '0;
        end else if (step) begin
            count <= count_up;
        end else if (edit_tick && !edit_lock) begin
            // add wins when both buttons are held
            if (add) begin
                count <= count_up;
            end else if (sub) begin
                count <= count_down;
            end
        end
    end

    count_in_range: assert property (
        @(posedge clk_src) disable iff (!rst_n) count < RANGE
    );

endmodule

// File: source/timing_clock.sv
module timing_clock #(
    parameter int unsigned NUM        = 5,
    parameter int unsigned MIN_RANGE  = 60,
    parameter int unsigned HOUR_RANGE = 24
) (
    input  logic                   clk_src,
    input  logic                   rst_n,
    input  logic                   reset,
    input  logic                   power,
    input  logic                   timing_clock_switch,
    input  logic                   timing_clock_disable,
    input  logic                   edit_tick,
    input  clock_pkg::unit_sel_t   add_time,
    input  clock_pkg::unit_sel_t   sub_time,
    input  clock_pkg::clock_time_t now,
    output clock_pkg::clock_time_t show_time,
    output logic [NUM-1:0]         timing_clock_alarm
);

    localparam int unsigned sel_w = (NUM > 1) ? $clog2(NUM) : 1;
    localparam logic [clock_pkg::unit_w-1:0] min_top  = clock_pkg::unit_w'(MIN_RANGE - 1);
    localparam logic [clock_pkg::unit_w-1:0] hour_top = clock_pkg::unit_w'(HOUR_RANGE - 1);

    clock_pkg::clock_time_t slot [NUM];
    clock_pkg::clock_time_t cur;
    clock_pkg::clock_time_t edited;
    logic [NUM-1:0]         armed;
    logic [sel_w-1:0]       sel;
    logic                   edit_en;
    logic                   slot_edit;

    assign cur       = slot[sel];
    assign edit_en   = edit_tick & timing_clock_switch & power;
    assign slot_edit = add_time.hour | sub_time.hour | add_time.min | sub_time.min;

    // hour and minute of the selected slot after one edit step
    always_comb begin
        edited = cur;
        if (add_time.hour) begin
            edited.hour = (cur.hour == hour_top) ? '0 : cur.hour + 1'b1;
        end else if (sub_time.hour) begin
            edited.hour = (cur.hour == '0) ? hour_top : cur.hour - 1'b1;
        end
        if (add_time.min) begin
            edited.min = (cur.min == min_top) ? '0 : cur.min + 1'b1;
        end else if (sub_time.min) begin
            edited.min = (cur.min == '0) ? min_top : cur.min - 1'b1;
        end
    end

    always_ff @(posedge clk_src or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM; k++) begin
                slot[k] <= clock_pkg::time_zero;
            end
            sel <= '0;
        end else if (reset) begin
            for (int k = 0; k < NUM; k++) begin
                slot[k] <= clock_pkg::time_zero;
            end
            sel <= '0;
        end else if (edit_en) begin
            if (slot_edit) begin
                slot[sel] <= edited;
            end
            // sec add button steps through the slots
            if (add_time.sec) begin
                sel <= (sel == sel_w'(NUM - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    // match on hour and minute, one cycle behind now
    always_ff @(posedge clk_src or negedge rst_n) begin
        if (!rst_n) begin
            armed              <= '0;
            timing_clock_alarm <= '0;
        end else if (reset) begin
            armed              <= '0;
            timing_clock_alarm <= '0;
        end else begin
            for (int k = 0; k < NUM; k++) begin
                timing_clock_alarm[k] <= power & armed[k] & ~timing_clock_disable &
                    (slot[k].hour == now.hour) & (slot[k].min == now.min);
                if (timing_clock_disable && timing_clock_alarm[k]) begin
                    armed[k] <= 1'b0;
                end
            end
            if (edit_en && slot_edit) begin
                armed[sel] <= 1'b1;
            end
        end
    end

    assign show_time = '{hour: cur.hour, min: cur.min, sec: '0};

    sel_in_range: assert property (
        @(posedge clk_src) disable iff (!rst_n) sel < NUM
    );

endmodule

// File: src.f
source/clock_pkg.sv
source/tick_divider.sv
source/timer.sv
source/timing_clock.sv
source/ring.sv
source/time_displayer.sv
source/clock.sv
verification/clock_tb.sv

// File: verification/clock_input.txt
# command then three decimal operands a b c, units 0 sec 1 min 2 hour
# run n en | add u | sub u | switch v | disable | power v | time h m s | dark | slots mask | alarm n lvl
time 0 0 0
run 5 1 0
time 0 0 5
run 4 0 0
time 0 0 5
power 0 0 0
dark 0 0 0
run 2 1 0
power 1 0 0
time 0 0 5
sub 1 0 0
sub 2 0 0
time 23 59 5
run 55 1 0
time 0 0 0
sub 0 0 0
add 0 0 0
run 4 1 0
alarm 3 0 0
switch 1 0 0
add 2 0 0
time 1 0 0
add 0 0 0
add 1 0 0
time 0 1 0
switch 0 0 0
time 0 0 4
run 57 1 0
slots 2 0 0
disable 0 0 0
slots 0 0 0
add 2 0 0
sub 1 0 0
slots 1 0 0
time 1 0 1

// File: verification/clock_tb.sv
module clock_tb;

    localparam int unsigned tick_div = 8;
    localparam int unsigned edit_div = 4;
    localparam int unsigned scan_div = 2;
    localparam int unsigned len      = 3;
    localparam int unsigned num      = 2;

    logic                 clk_src;
    logic                 rst_n;
    logic                 power;
    logic                 enable;
    logic                 reset;
    clock_pkg::unit_sel_t add_time;
    clock_pkg::unit_sel_t sub_time;
    logic                 timing_clock_switch;
    logic                 timing_clock_disable;
    logic                 alarm;
    logic [num-1:0]       timing_clock_alarm;
    logic [7:0]           anodes;
    logic [7:0]           cnodes;

    // reference model of the running time, the slots and the chime
    int             model_h;
    int             model_m;
    int             model_s;
    int             slot_h [num];
    int             slot_m [num];
    logic [num-1:0] armed;
    int             sel;
    int             chime_left;
    int             alarm_ticks;

    int     pass_count;
    int     fail_count;
    int     test_errors;
    longint time_limit;
    string  cmd_q [$];
    int     a_q [$];
    int     b_q [$];
    int     c_q [$];

    clock #(
        .TICK_DIV(tick_div),
        .EDIT_DIV(edit_div),
        .SCAN_DIV(scan_div),
        .LEN(len),
        .NUM(num)
    ) dut (
        .clk_src(clk_src), .rst_n(rst_n), .power(power), .enable(enable), .reset(reset),
        .add_time(add_time), .sub_time(sub_time),
        .timing_clock_switch(timing_clock_switch),
        .timing_clock_disable(timing_clock_disable),
        .alarm(alarm), .timing_clock_alarm(timing_clock_alarm),
        .anodes(anodes), .cnodes(cnodes)
    );

    always #5 clk_src = ~clk_src;

    function automatic int wrap_unit(input int value, input int range);
        return (value + range) % range;
    endfunction

    // back from a segment code to its digit, -1 for anything else
    function automatic int seg_digit(input logic [7:0] code);
        for (int d = 0; d < 10; d++) begin
            if (clock_pkg::seg_code(4'(d)) == code) begin
                return d;
            end
        end
        return -1;
    endfunction

    task automatic compare_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, expected);
            test_errors++;
        end
    endtask

    task automatic advance_model();
        if (chime_left > 0) begin
            chime_left--;
        end
        model_s = (model_s + 1) % 60;
        if (model_s == 0) begin
            model_m = (model_m + 1) % 60;
            if (model_m == 0) begin
                model_h = (model_h + 1) % 24;
                chime_left = len;
            end
        end
    endtask

    task automatic apply_edit(input int unit, input logic up);
        int step;
        step = up ? 1 : -1;
        if (!power) begin
            return;
        end
        if (!timing_clock_switch) begin
            if (unit == 0) begin
                model_s = wrap_unit(model_s + step, 60);
            end else if (unit == 1) begin
                model_m = wrap_unit(model_m + step, 60);
            end else begin
                model_h = wrap_unit(model_h + step, 24);
            end
        end else if (unit == 0) begin
            // sec add picks the next slot, sec sub does nothing
            if (up) begin
                sel = (sel + 1) % num;
            end
        end else begin
            if (unit == 1) begin
                slot_m[sel] = wrap_unit(slot_m[sel] + step, 60);
            end else begin
                slot_h[sel] = wrap_unit(slot_h[sel] + step, 24);
            end
            armed[sel] = 1'b1;
        end
    endtask

    task automatic run_seconds(input int n, input logic en);
        int seen;
        seen = 0;
        alarm_ticks = 0;
        enable = en;
        if (en && power) begin
            while (seen < n) begin
                @(negedge clk_src);
                if (dut.sec_tick) begin
                    seen++;
                    if (alarm) begin
                        alarm_ticks++;
                    end
                    if (int'(alarm) != int'(chime_left > 0)) begin
                        $display("[FAIL] alarm: got 0x%0h expected 0x%0h", alarm, chime_left > 0);
                        test_errors++;
                    end
                    advance_model();
                end
            end
            // enable stays up while the chime sees the rollover
            repeat (2) @(posedge clk_src);
        end else begin
            repeat (n * tick_div) @(posedge clk_src);
        end
        #1;
        enable = 1'b0;
    endtask

    task automatic press_button(input int unit, input logic up);
        if (up) begin
            add_time = clock_pkg::unit_sel_t'(3'b001 << unit);
        end else begin
            sub_time = clock_pkg::unit_sel_t'(3'b001 << unit);
        end
        // held for exactly one edit strobe
        @(negedge clk_src);
        while (!dut.edit_tick) begin
            @(negedge clk_src);
        end
        @(posedge clk_src);
        #1;
        add_time = '0;
        sub_time = '0;
        apply_edit(unit, up);
    endtask

    task automatic pulse_disable();
        for (int k = 0; k < num; k++) begin
            if (power && armed[k] && slot_h[k] == model_h && slot_m[k] == model_m) begin
                armed[k] = 1'b0;
            end
        end
        timing_clock_disable = 1'b1;
        repeat (3) @(posedge clk_src);
        #1;
        timing_clock_disable = 1'b0;
    endtask

    task automatic verify_display_time(input int h, input int m, input int s);
        int digit [8];
        int exp_h;
        int exp_m;
        int exp_s;
        exp_h = timing_clock_switch ? slot_h[sel] : model_h;
        exp_m = timing_clock_switch ? slot_m[sel] : model_m;
        exp_s = timing_clock_switch ? 0 : model_s;
        if (exp_h != h || exp_m != m || exp_s != s) begin
            $display("script time %0d:%0d:%0d does not match the reference model", h, m, s);
            test_errors++;
        end
        for (int i = 0; i < 8; i++) begin
            digit[i] = -1;
        end
        // latency first, then two full scans
        repeat (scan_div * 8 + 2) @(posedge clk_src);
        repeat (scan_div * 16) begin
            @(negedge clk_src);
            if ($countones(~anodes) != 1) begin
                $display("anodes 0x%0h do not select exactly one digit", anodes);
                test_errors++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    if (!anodes[i]) begin
                        digit[i] = seg_digit(cnodes);
                    end
                end
            end
        end
        @(posedge clk_src);
        #1;
        if (digit[5] != -1 || digit[2] != -1) begin
            $display("a separator digit is not blank");
            test_errors++;
        end
        compare_value("display hour", digit[7] * 10 + digit[6], h);
        compare_value("display min", digit[4] * 10 + digit[3], m);
        compare_value("display sec", digit[1] * 10 + digit[0], s);
    endtask

    task automatic expect_blank_display();
        repeat (2) @(posedge clk_src);
        repeat (scan_div * 8) begin
            @(negedge clk_src);
            compare_value("anodes", int'(anodes), 'hff);
            compare_value("cnodes", int'(cnodes), 'hff);
        end
        @(posedge clk_src);
        #1;
    endtask

    task automatic inspect_slot_alarms(input int mask);
        logic [num-1:0] expected;
        expected = '0;
        for (int k = 0; k < num; k++) begin
            expected[k] = power && armed[k] && slot_h[k] == model_h && slot_m[k] == model_m;
        end
        if (int'(expected) != mask) begin
            $display("script slot mask %0h does not match the reference model", mask);
            test_errors++;
        end
        repeat (2) @(posedge clk_src);
        @(negedge clk_src);
        compare_value("timing_clock_alarm", int'(timing_clock_alarm), mask);
        @(posedge clk_src);
        #1;
    endtask

    task automatic measure_chime(input int seconds, input int level);
        @(negedge clk_src);
        compare_value("alarm seconds", alarm_ticks, seconds);
        compare_value("alarm", int'(alarm), level);
        @(posedge clk_src);
        #1;
    endtask

    // ends a run that stops making progress
    initial begin
        wait (time_limit > 0);
        #(time_limit);
        $display("watchdog expired before the command script finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int     fd;
        int     n;
        int     a;
        int     b;
        int     c;
        longint run_total;
        string  word;
        string  rest;
        clk_src              = 1'b0;
        rst_n                = 1'b0;
        power                = 1'b1;
        enable               = 1'b0;
        reset                = 1'b0;
        add_time             = '0;
        sub_time             = '0;
        timing_clock_switch  = 1'b0;
        timing_clock_disable = 1'b0;
        model_h     = 0;
        model_m     = 0;
        model_s     = 0;
        armed       = '0;
        sel         = 0;
        chime_left  = 0;
        alarm_ticks = 0;
        pass_count  = 0;
        fail_count  = 0;
        time_limit  = 0;
        run_total   = 0;
        for (int k = 0; k < num; k++) begin
            slot_h[k] = 0;
            slot_m[k] = 0;
        end

        fd = $fopen("verification/clock_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the command script");
            fail_count++;
        end else begin
            while ($fscanf(fd, "%s", word) == 1) begin
                if (word == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    n = $fscanf(fd, "%d %d %d", a, b, c);
                    if (n != 3) begin
                        $display("malformed script line for command %s", word);
                        fail_count++;
                    end
                    cmd_q.push_back(word);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                    if (word == "run") begin
                        run_total += a;
                    end
                end
            end
            $fclose(fd);
        end
        time_limit = (run_total * tick_div + longint'(cmd_q.size()) * 200 + 200) * 10;

        repeat (10) @(posedge clk_src);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < cmd_q.size(); i++) begin
            test_errors = 0;
            a = a_q[i];
            b = b_q[i];
            c = c_q[i];
            if (cmd_q[i] == "run") begin
                run_seconds(a, b != 0);
            end else if (cmd_q[i] == "add") begin
                press_button(a, 1'b1);
            end else if (cmd_q[i] == "sub") begin
                press_button(a, 1'b0);
            end else if (cmd_q[i] == "switch" || cmd_q[i] == "power") begin
                if (cmd_q[i] == "switch") begin
                    timing_clock_switch = (a != 0);
                end else begin
                    power = (a != 0);
                    chime_left = power ? chime_left : 0;
                end
                @(posedge clk_src);
                #1;
            end else if (cmd_q[i] == "disable") begin
                pulse_disable();
            end else if (cmd_q[i] == "time") begin
                verify_display_time(a, b, c);
            end else if (cmd_q[i] == "dark") begin
                expect_blank_display();
            end else if (cmd_q[i] == "slots") begin
                inspect_slot_alarms(a);
            end else if (cmd_q[i] == "alarm") begin
                measure_chime(a, b);
            end else begin
                $display("unknown command %s in the script", cmd_q[i]);
                test_errors++;
            end
            if (test_errors == 0) begin
                pass_count++;
                $display("test %0d %s %0d %0d %0d: ok", i + 1, cmd_q[i], a, b, c);
            end else begin
                fail_count++;
                $display("test %0d %s %0d %0d %0d: wrong", i + 1, cmd_q[i], a, b, c);
            end
        end

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
